/* design/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Station depths
`define ALU_RS_SIZE    4
`define BRANCH_RS_SIZE 2

// Slot index widths follow the depths
`define ALU_IDX_W    $clog2(`ALU_RS_SIZE)
`define BRANCH_IDX_W $clog2(`BRANCH_RS_SIZE)

// Reorder tag width, 16 tags
`define ROB_IDX_W 4

// Instructions dispatched per cycle
`define ISSUE_W 2

// Operand words read from the ROB per cycle
`define ROB_READ_W (`ISSUE_W * 2)

`endif

/* design/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

typedef logic [`ROB_IDX_W-1:0] rob_index_t;

typedef enum logic [3:0] {
	ALU_ADD  = 4'd0, // traps on signed overflow
	ALU_ADDU = 4'd1,
	ALU_SUB  = 4'd2,
	ALU_AND  = 4'd3,
	ALU_OR   = 4'd4,
	ALU_XOR  = 4'd5,
	ALU_SLT  = 4'd6,
	ALU_SLL  = 4'd7,
	ALU_SRL  = 4'd8
} alu_op_t;

typedef enum logic [3:0] {
	BR_BEQ  = 4'd0,
	BR_BNE  = 4'd1,
	BR_BLEZ = 4'd2,
	BR_BGTZ = 4'd3,
	BR_JUMP = 4'd4
} branch_op_t;

// Same op bits, read by whichever station holds the entry
typedef union packed {
	alu_op_t    alu;
	branch_op_t branch;
} fu_op_u;

typedef struct packed {
	logic                   valid;
	fu_op_u                 op;
	rob_index_t             reorder;
	logic [1:0][31:0]       operand;
	logic [1:0]             operand_ready;
	rob_index_t [1:0]       operand_addr;
	logic [31:0]            pc;
	logic [31:0]            imm; // offset in words
} reserve_station_t;

typedef struct packed {
	logic        taken;
	logic [31:0] target;
} branch_resolved_t;

typedef struct packed {
	logic        valid;
	rob_index_t  reorder;
	logic [31:0] value;
	logic        ex;
	logic        is_branch;
	logic        taken;
	logic [31:0] target;
} cdb_packet_t;

endpackage

/* design/read_operands.sv */
`include "cpu_defs.svh"

module read_operands(
	input  cpu_pkg::cdb_packet_t      cdb_packet_i,
	input  cpu_pkg::reserve_station_t rs_i,
	output cpu_pkg::reserve_station_t rs_o
);

logic [1:0] hit;

// Tag match against the broadcast, only for operands still waiting
always_comb begin
	for (int j = 0; j < 2; ++j) begin
		hit[j] = cdb_packet_i.valid
			&& !rs_i.operand_ready[j]
			&& (cdb_packet_i.reorder == rs_i.operand_addr[j]);
	end
end

always_comb begin
	rs_o = rs_i;
	for (int j = 0; j < 2; ++j) begin
		if (hit[j]) begin
			rs_o.operand[j]       = cdb_packet_i.value;
			rs_o.operand_ready[j] = 1'b1;
		end
	end
end

endmodule

/* design/alu_rs.sv */
`include "cpu_defs.svh"

module alu_rs(
	input  logic                                            clk,
	input  logic                                            reset_i,
	input  logic                                            flush_i,

	// Dispatch
	input  logic [`ISSUE_W-1:0]                             rs_taken_i,
	output logic [`ISSUE_W-1:0]                             rs_ready_o,
	output logic [`ISSUE_W-1:0][`ALU_IDX_W-1:0]             rs_index_o,
	input  cpu_pkg::reserve_station_t [`ISSUE_W-1:0]        rs_i,

	// Wakeup
	input  cpu_pkg::cdb_packet_t                            cdb_i,

	// Results, one per slot
	output logic [`ALU_RS_SIZE-1:0][31:0]                   data_o,
	output logic [`ALU_RS_SIZE-1:0]                         data_ready_o,
	output cpu_pkg::rob_index_t [`ALU_RS_SIZE-1:0]          data_reorder_o,
	output logic [`ALU_RS_SIZE-1:0]                         ex_o,
	input  logic [`ALU_RS_SIZE-1:0]                         data_ack_i
);

localparam int IDX_W = `ALU_IDX_W;

cpu_pkg::reserve_station_t [`ALU_RS_SIZE-1:0] entry_q;
cpu_pkg::reserve_station_t [`ALU_RS_SIZE-1:0] entry_wake;

// Hand out the two lowest free slots
always_comb begin
	rs_ready_o = '0;
	rs_index_o = '0;
	for (int i = 0; i < `ALU_RS_SIZE; ++i) begin
		if (!entry_q[i].valid) begin
			if (!rs_ready_o[0]) begin
				rs_ready_o[0] = 1'b1;
				rs_index_o[0] = IDX_W'(i);
			end else if (!rs_ready_o[1]) begin
				rs_ready_o[1] = 1'b1;
				rs_index_o[1] = IDX_W'(i);
			end
		end
	end
end

always_ff @(posedge clk) begin
	if (reset_i || flush_i) begin
		for (int i = 0; i < `ALU_RS_SIZE; ++i)
			entry_q[i].valid <= 1'b0;
	end else begin
		for (int i = 0; i < `ALU_RS_SIZE; ++i) begin
			entry_q[i] <= entry_wake[i];
			if (data_ack_i[i])
				entry_q[i].valid <= 1'b0;
		end
		for (int k = 0; k < `ISSUE_W; ++k) begin
			if (rs_taken_i[k]) begin
				entry_q[rs_index_o[k]]       <= rs_i[k];
				entry_q[rs_index_o[k]].valid <= 1'b1;
			end
		end
	end
end

for (genvar i = 0; i < `ALU_RS_SIZE; ++i) begin : gen_slot
	logic [31:0] a, b;
	logic [31:0] sum, diff;
	logic [31:0] result;
	logic        overflow;

	read_operands read_operands_i(
		.cdb_packet_i ( cdb_i         ),
		.rs_i         ( entry_q[i]    ),
		.rs_o         ( entry_wake[i] )
	);

	assign a    = entry_q[i].operand[0];
	assign b    = entry_q[i].operand[1];
	assign sum  = a + b;
	assign diff = a - b;

	always_comb begin
		overflow = 1'b0;
		case (entry_q[i].op.alu)
			cpu_pkg::ALU_ADD: begin
				result   = sum;
				// Same input signs, different result sign
				overflow = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			cpu_pkg::ALU_ADDU: result = sum;
			cpu_pkg::ALU_SUB:  result = diff;
			cpu_pkg::ALU_AND:  result = a & b;
			cpu_pkg::ALU_OR:   result = a | b;
			cpu_pkg::ALU_XOR:  result = a ^ b;
			cpu_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
			cpu_pkg::ALU_SLL:  result = a << b[4:0];
			cpu_pkg::ALU_SRL:  result = a >> b[4:0];
			default:           result = '0;
		endcase
	end

	assign data_o[i]         = result;
	assign ex_o[i]           = overflow;
	assign data_ready_o[i]   = entry_q[i].valid && (&entry_q[i].operand_ready);
	assign data_reorder_o[i] = entry_q[i].reorder;
end

endmodule

/* design/branch_rs.sv */
`include "cpu_defs.svh"

module branch_rs(
	input  logic                                            clk,
	input  logic                                            reset_i,
	input  logic                                            flush_i,

	// Dispatch
	input  logic [`ISSUE_W-1:0]                             rs_taken_i,
	output logic [`ISSUE_W-1:0]                             rs_ready_o,
	output logic [`ISSUE_W-1:0][`BRANCH_IDX_W-1:0]          rs_index_o,
	input  cpu_pkg::reserve_station_t [`ISSUE_W-1:0]        rs_i,

	// Wakeup
	input  cpu_pkg::cdb_packet_t                            cdb_i,

	// Results, one per slot
	output logic [`BRANCH_RS_SIZE-1:0][31:0]                data_o,
	output logic [`BRANCH_RS_SIZE-1:0]                      data_ready_o,
	output cpu_pkg::rob_index_t [`BRANCH_RS_SIZE-1:0]       data_reorder_o,
	output cpu_pkg::branch_resolved_t [`BRANCH_RS_SIZE-1:0] resolved_o,
	input  logic [`BRANCH_RS_SIZE-1:0]                      data_ack_i
);

localparam int IDX_W = `BRANCH_IDX_W;

cpu_pkg::reserve_station_t [`BRANCH_RS_SIZE-1:0] entry_q;
cpu_pkg::reserve_station_t [`BRANCH_RS_SIZE-1:0] entry_wake;

// Lowest free slot to lane 0, next one to lane 1
always_comb begin
	rs_ready_o = '0;
	rs_index_o = '0;
	for (int i = 0; i < `BRANCH_RS_SIZE; ++i) begin
		if (!entry_q[i].valid) begin
			if (!rs_ready_o[0]) begin
				rs_ready_o[0] = 1'b1;
				rs_index_o[0] = IDX_W'(i);
			end else if (!rs_ready_o[1]) begin
				rs_ready_o[1] = 1'b1;
				rs_index_o[1] = IDX_W'(i);
			end
		end
	end
end

always_ff @(posedge clk) begin
	if (reset_i || flush_i) begin
		for (int i = 0; i < `BRANCH_RS_SIZE; ++i)
			entry_q[i].valid <= 1'b0;
	end else begin
		for (int i = 0; i < `BRANCH_RS_SIZE; ++i) begin
			entry_q[i] <= entry_wake[i];
			if (data_ack_i[i])
				entry_q[i].valid <= 1'b0;
		end
		for (int k = 0; k < `ISSUE_W; ++k) begin
			if (rs_taken_i[k]) begin
				entry_q[rs_index_o[k]]       <= rs_i[k];
				entry_q[rs_index_o[k]].valid <= 1'b1;
			end
		end
	end
end

for (genvar i = 0; i < `BRANCH_RS_SIZE; ++i) begin : gen_slot
	logic [31:0] a, b;
	logic        taken;

	read_operands read_operands_i(
		.cdb_packet_i ( cdb_i         ),
		.rs_i         ( entry_q[i]    ),
		.rs_o         ( entry_wake[i] )
	);

	assign a = entry_q[i].operand[0];
	assign b = entry_q[i].operand[1];

	always_comb begin
		case (entry_q[i].op.branch)
			cpu_pkg::BR_BEQ:  taken = (a == b);
			cpu_pkg::BR_BNE:  taken = (a != b);
			cpu_pkg::BR_BLEZ: taken = $signed(a) <= 0;
			cpu_pkg::BR_BGTZ: taken = $signed(a) > 0;
			cpu_pkg::BR_JUMP: taken = 1'b1;
			default:          taken = 1'b0;
		endcase
	end

	// Offset counts words from the delay slot
	assign resolved_o[i].target = entry_q[i].pc + 32'd4 + {entry_q[i].imm[29:0], 2'b00};
	assign resolved_o[i].taken  = taken;

	// Link value skips the delay slot
	assign data_o[i]         = entry_q[i].pc + 32'd8;
	assign data_ready_o[i]   = entry_q[i].valid && (&entry_q[i].operand_ready);
	assign data_reorder_o[i] = entry_q[i].reorder;
end

endmodule

/* design/cdb_arbitrator.sv */
`include "cpu_defs.svh"

module cdb_arbitrator(
	input  logic                                            clk,
	input  logic                                            reset_i,
	input  logic                                            flush_i,

	// ALU station
	input  logic [`ALU_RS_SIZE-1:0][31:0]                   alu_data_i,
	input  logic [`ALU_RS_SIZE-1:0]                         alu_data_ready_i,
	input  cpu_pkg::rob_index_t [`ALU_RS_SIZE-1:0]          alu_data_reorder_i,
	input  logic [`ALU_RS_SIZE-1:0]                         alu_ex_i,
	output logic [`ALU_RS_SIZE-1:0]                         alu_ack_o,

	// Branch station
	input  logic [`BRANCH_RS_SIZE-1:0][31:0]                branch_data_i,
	input  logic [`BRANCH_RS_SIZE-1:0]                      branch_data_ready_i,
	input  cpu_pkg::rob_index_t [`BRANCH_RS_SIZE-1:0]       branch_data_reorder_i,
	input  cpu_pkg::branch_resolved_t [`BRANCH_RS_SIZE-1:0] branch_resolved_i,
	output logic [`BRANCH_RS_SIZE-1:0]                      branch_ack_o,

	output cpu_pkg::cdb_packet_t                            cdb_o
);

cpu_pkg::cdb_packet_t cdb_d;

// Branches first, lowest slot first
always_comb begin
	logic found;
	found        = 1'b0;
	alu_ack_o    = '0;
	branch_ack_o = '0;
	cdb_d        = '0;
	for (int i = 0; i < `BRANCH_RS_SIZE; ++i) begin
		if (!found && branch_data_ready_i[i]) begin
			found           = 1'b1;
			branch_ack_o[i] = 1'b1;
			cdb_d.valid     = 1'b1;
			cdb_d.reorder   = branch_data_reorder_i[i];
			cdb_d.value     = branch_data_i[i];
			cdb_d.is_branch = 1'b1;
			cdb_d.taken     = branch_resolved_i[i].taken;
			cdb_d.target    = branch_resolved_i[i].target;
		end
	end
	for (int i = 0; i < `ALU_RS_SIZE; ++i) begin
		if (!found && alu_data_ready_i[i]) begin
			found         = 1'b1;
			alu_ack_o[i]  = 1'b1;
			cdb_d.valid   = 1'b1;
			cdb_d.reorder = alu_data_reorder_i[i];
			cdb_d.value   = alu_data_i[i];
			cdb_d.ex      = alu_ex_i[i];
		end
	end
end

always_ff @(posedge clk) begin
	if (reset_i || flush_i)
		cdb_o.valid <= 1'b0;
	else
		cdb_o <= cdb_d;
end

endmodule

/* design/instr_exec.sv */
`include "cpu_defs.svh"

module instr_exec(
	input  logic                                            clk,
	input  logic                                            reset_i,
	input  logic                                            flush_i,

	// Dispatch
	input  cpu_pkg::reserve_station_t [`ISSUE_W-1:0]        rs_i,

	input  logic [`ISSUE_W-1:0]                             alu_taken_i,
	output logic [`ISSUE_W-1:0]                             alu_ready_o,
	output logic [`ISSUE_W-1:0][`ALU_IDX_W-1:0]             alu_index_o,

	input  logic [`ISSUE_W-1:0]                             branch_taken_i,
	output logic [`ISSUE_W-1:0]                             branch_ready_o,
	output logic [`ISSUE_W-1:0][`BRANCH_IDX_W-1:0]          branch_index_o,

	// ROB operand read
	output cpu_pkg::rob_index_t [`ROB_READ_W-1:0]           rob_raddr_o,
	input  logic [`ROB_READ_W-1:0]                          rob_rdata_valid_i,
	input  logic [`ROB_READ_W-1:0][31:0]                    rob_rdata_i,

	output cpu_pkg::cdb_packet_t                            cdb_o
);

cpu_pkg::cdb_packet_t cdb;
cpu_pkg::reserve_station_t [`ISSUE_W-1:0] rs_rob, rs_snoop;

logic [`ALU_RS_SIZE-1:0][31:0]                   alu_data;
logic [`ALU_RS_SIZE-1:0]                         alu_data_ready;
cpu_pkg::rob_index_t [`ALU_RS_SIZE-1:0]          alu_data_reorder;
logic [`ALU_RS_SIZE-1:0]                         alu_ex;
logic [`ALU_RS_SIZE-1:0]                         alu_ack;

logic [`BRANCH_RS_SIZE-1:0][31:0]                branch_data;
logic [`BRANCH_RS_SIZE-1:0]                      branch_data_ready;
cpu_pkg::rob_index_t [`BRANCH_RS_SIZE-1:0]       branch_data_reorder;
cpu_pkg::branch_resolved_t [`BRANCH_RS_SIZE-1:0] branch_resolved;
logic [`BRANCH_RS_SIZE-1:0]                      branch_ack;

assign cdb_o = cdb;

// Two ROB ports per lane
for (genvar i = 0; i < `ISSUE_W; ++i) begin : gen_rob_addr
	assign rob_raddr_o[i * 2]     = rs_i[i].operand_addr[0];
	assign rob_raddr_o[i * 2 + 1] = rs_i[i].operand_addr[1];
end

always_comb begin
	rs_rob = rs_i;
	for (int i = 0; i < `ISSUE_W; ++i) begin
		for (int j = 0; j < 2; ++j) begin
			if (!rs_i[i].operand_ready[j] && rob_rdata_valid_i[i * 2 + j]) begin
				rs_rob[i].operand[j]       = rob_rdata_i[i * 2 + j];
				rs_rob[i].operand_ready[j] = 1'b1;
			end
		end
	end
end

// Catch a producer broadcasting in the dispatch cycle
for (genvar i = 0; i < `ISSUE_W; ++i) begin : gen_dispatch_snoop
	read_operands read_operands_i(
		.cdb_packet_i ( cdb         ),
		.rs_i         ( rs_rob[i]   ),
		.rs_o         ( rs_snoop[i] )
	);
end

alu_rs alu_rs_i(
	.clk,
	.reset_i,
	.flush_i,
	.rs_taken_i     ( alu_taken_i      ),
	.rs_ready_o     ( alu_ready_o      ),
	.rs_index_o     ( alu_index_o      ),
	.rs_i           ( rs_snoop         ),
	.cdb_i          ( cdb              ),
	.data_o         ( alu_data         ),
	.data_ready_o   ( alu_data_ready   ),
	.data_reorder_o ( alu_data_reorder ),
	.ex_o           ( alu_ex           ),
	.data_ack_i     ( alu_ack          )
);

branch_rs branch_rs_i(
	.clk,
	.reset_i,
	.flush_i,
	.rs_taken_i     ( branch_taken_i      ),
	.rs_ready_o     ( branch_ready_o      ),
	.rs_index_o     ( branch_index_o      ),
	.rs_i           ( rs_snoop            ),
	.cdb_i          ( cdb                 ),
	.data_o         ( branch_data         ),
	.data_ready_o   ( branch_data_ready   ),
	.data_reorder_o ( branch_data_reorder ),
	.resolved_o     ( branch_resolved     ),
	.data_ack_i     ( branch_ack          )
);

cdb_arbitrator cdb_arbitrator_i(
	.clk,
	.reset_i,
	.flush_i,
	.alu_data_i            ( alu_data            ),
	.alu_data_ready_i      ( alu_data_ready      ),
	.alu_data_reorder_i    ( alu_data_reorder    ),
	.alu_ex_i              ( alu_ex              ),
	.alu_ack_o             ( alu_ack             ),
	.branch_data_i         ( branch_data         ),
	.branch_data_ready_i   ( branch_data_ready   ),
	.branch_data_reorder_i ( branch_data_reorder ),
	.branch_resolved_i     ( branch_resolved     ),
	.branch_ack_o          ( branch_ack          ),
	.cdb_o                 ( cdb                 )
);

endmodule

/* test/instr_exec_tb.sv */
`include "cpu_defs.svh"

module instr_exec_tb;
timeunit 1ns;
timeprecision 100ps;

localparam int COLS = 13;
localparam int MAX_LINES = 64;

// Golden file columns
typedef enum int {F_KIND, F_OP, F_OPND_A, F_OPND_B, F_SRC_A, F_SRC_B, F_PC, F_IMM,
	F_DEST, F_VALUE, F_EX, F_TAKEN, F_TARGET} column_e;

logic clk;
logic reset_i;
logic flush_i;
cpu_pkg::reserve_station_t [`ISSUE_W-1:0] rs_i;
logic [`ISSUE_W-1:0] alu_taken_i;
logic [`ISSUE_W-1:0] alu_ready_o;
logic [`ISSUE_W-1:0][`ALU_IDX_W-1:0] alu_index_o;
logic [`ISSUE_W-1:0] branch_taken_i;
logic [`ISSUE_W-1:0] branch_ready_o;
logic [`ISSUE_W-1:0][`BRANCH_IDX_W-1:0] branch_index_o;
cpu_pkg::rob_index_t [`ROB_READ_W-1:0] rob_raddr_o;
logic [`ROB_READ_W-1:0] rob_rdata_valid_i;
logic [`ROB_READ_W-1:0][31:0] rob_rdata_i;
cpu_pkg::cdb_packet_t cdb_o;

logic [31:0] golden [MAX_LINES*COLS];
logic [15:0] rob_done;
logic [31:0] rob_value [16];
int tag_owner [16];
int line_count [MAX_LINES];
bit line_flushed [MAX_LINES];
int n_lines;
int next_line;
int in_flight;
int cycles = 0;
int cycle_limit;
logic [31:0] lfsr;

instr_exec instr_exec_i(.*);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

// ROB model answers the operand read in the same cycle
always_comb begin
	for (int p = 0; p < `ROB_READ_W; ++p) begin
		rob_rdata_valid_i[p] = rob_done[rob_raddr_o[p]];
		rob_rdata_i[p]       = rob_value[rob_raddr_o[p]];
	end
end

always @(posedge clk) begin
	cycles++;
	if (cycles > cycle_limit)
		stop_run($sformatf("Run timed out after %0d cycles", cycles));
end

task automatic stop_run(input string msg);
	$display("%s", msg);
	$display("Finished with errors");
	$fatal(1, "run stopped");
endtask

task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
	if (got !== expected)
		stop_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected));
endtask

function automatic logic [31:0] field(int line, int col);
	return golden[line * COLS + col];
endfunction

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

function automatic cpu_pkg::reserve_station_t build_entry(int line);
	cpu_pkg::reserve_station_t e;
	logic [31:0] op;
	logic [31:0] src;
	e = '0;
	op = field(line, F_OP);
	e.valid = 1'b1;
	if (field(line, F_KIND) == 0)
		e.op.alu = cpu_pkg::alu_op_t'(op[3:0]);
	else
		e.op.branch = cpu_pkg::branch_op_t'(op[3:0]);
	e.reorder = cpu_pkg::rob_index_t'(field(line, F_DEST));
	for (int j = 0; j < 2; ++j) begin
		src = field(line, F_SRC_A + j);
		// 0x10 marks an operand that is already known
		if (src == 32'h10) begin
			e.operand[j]       = field(line, F_OPND_A + j);
			e.operand_ready[j] = 1'b1;
		end else begin
			e.operand_addr[j] = src[3:0];
		end
	end
	e.pc  = field(line, F_PC);
	e.imm = field(line, F_IMM);
	return e;
endfunction

task automatic check_cdb();
	int line;
	if (cdb_o.valid) begin
		line = tag_owner[cdb_o.reorder];
		if (line < 0) begin
			stop_run($sformatf("Tag %0d was broadcast at %0t ns but is not in flight",
				cdb_o.reorder, $time));
		end else begin
			check_value($sformatf("tag %0d value", line), cdb_o.value, field(line, F_VALUE));
			check_value("ex", 32'(cdb_o.ex), field(line, F_EX));
			check_value("is_branch", 32'(cdb_o.is_branch), 32'(field(line, F_KIND) == 1));
			check_value("taken", 32'(cdb_o.taken), field(line, F_TAKEN));
			check_value("target", cdb_o.target, field(line, F_TARGET));
			line_count[line]++;
			tag_owner[cdb_o.reorder]  = -1;
			rob_done[cdb_o.reorder]  = 1'b1;
			rob_value[cdb_o.reorder] = cdb_o.value;
			in_flight--;
		end
	end
endtask

task automatic dispatch_cycle();
	logic b0;
	logic b1;
	logic stop;
	int kind;
	stop = 1'b0;
	// Two ready lanes must name two different slots
	if (&alu_ready_o)
		check_value("ALU lanes name distinct slots",
			32'(alu_index_o[0] != alu_index_o[1]), 32'd1);
	if (&branch_ready_o)
		check_value("branch lanes name distinct slots",
			32'(branch_index_o[0] != branch_index_o[1]), 32'd1);
	for (int k = 0; k < `ISSUE_W; ++k) begin
		kind = int'(field(next_line, F_KIND));
		if (!stop && kind < 2) begin
			b0 = lfsr[0];
			lfsr = lfsr_next(lfsr);
			b1 = lfsr[0];
			lfsr = lfsr_next(lfsr);
			if (kind == 0 ? !alu_ready_o[k] : !branch_ready_o[k]) begin
				stop = 1'b1;
			end else if (b0 | b1) begin
				rs_i[k] = build_entry(next_line);
				if (kind == 0)
					alu_taken_i[k] = 1'b1;
				else
					branch_taken_i[k] = 1'b1;
				tag_owner[rs_i[k].reorder] = next_line;
				in_flight++;
				next_line++;
			end
		end
	end
endtask

// Dispatch in the flush cycle, which the DUT drops
task automatic drive_dropped_dispatch();
	int kind;
	kind = int'(field(next_line, F_KIND));
	if (kind == 0 && alu_ready_o[0]) begin
		rs_i[0] = build_entry(next_line);
		alu_taken_i[0] = 1'b1;
	end else if (kind == 1 && branch_ready_o[0]) begin
		rs_i[0] = build_entry(next_line);
		branch_taken_i[0] = 1'b1;
	end
endtask

task automatic apply_flush();
	for (int t = 0; t < 16; ++t) begin
		if (tag_owner[t] >= 0)
			line_flushed[tag_owner[t]] = 1'b1;
		tag_owner[t] = -1;
	end
	rob_done = '0;
	in_flight = 0;
endtask

initial begin
	reset_i = 1'b1;
	flush_i = 1'b0;
	rs_i = '0;
	alu_taken_i = '0;
	branch_taken_i = '0;
	rob_done = '0;
	in_flight = 0;
	next_line = 0;
	lfsr = 32'h357c1bd2;
	for (int t = 0; t < 16; ++t) begin
		tag_owner[t] = -1;
		rob_value[t] = '0;
	end
	for (int l = 0; l < MAX_LINES; ++l) begin
		line_count[l] = 0;
		line_flushed[l] = 1'b0;
	end
	$readmemh("test/instr_exec_golden.txt", golden);
	n_lines = 0;
	while (n_lines < MAX_LINES && field(n_lines, F_KIND) != 3)
		n_lines++;
	if (n_lines == MAX_LINES)
		stop_run("The golden file has no end marker");
	cycle_limit = 20 * n_lines + 100;
	repeat (5) @(posedge clk);
	@(negedge clk);
	reset_i = 1'b0;
	while (next_line < n_lines || in_flight != 0) begin
		@(negedge clk);
		check_cdb();
		alu_taken_i = '0;
		branch_taken_i = '0;
		if (field(next_line, F_KIND) != 2) begin
			dispatch_cycle();
		end else if (in_flight == field(next_line, F_OP)) begin
			// Op column holds the count of entries left waiting at the flush
			flush_i = 1'b1;
			apply_flush();
			next_line++;
			drive_dropped_dispatch();
			@(negedge clk);
			flush_i = 1'b0;
			alu_taken_i = '0;
			branch_taken_i = '0;
			check_value("cdb valid after flush", 32'(cdb_o.valid), 32'd0);
			check_value("ready lanes after flush", 32'({alu_ready_o, branch_ready_o}), 32'hf);
			// Empty stations hand out their two lowest slots
			check_value("ALU slot of lane 0 after flush", 32'(alu_index_o[0]), 32'd0);
			check_value("ALU slot of lane 1 after flush", 32'(alu_index_o[1]), 32'd1);
			check_value("branch slot of lane 0 after flush", 32'(branch_index_o[0]), 32'd0);
			check_value("branch slot of lane 1 after flush", 32'(branch_index_o[1]), 32'd1);
			@(negedge clk);
			check_value("cdb valid two cycles after flush", 32'(cdb_o.valid), 32'd0);
		end
	end
	for (int l = 0; l < n_lines; ++l) begin
		if (field(l, F_KIND) != 2 && !line_flushed[l])
			check_value($sformatf("broadcasts of golden line %0d", l), line_count[l], 32'd1);
	end
	$display("Finished with no errors");
	$finish;
end

endmodule

/* compile.f */
+incdir+design
design/cpu_pkg.sv
design/read_operands.sv
design/alu_rs.sv
design/branch_rs.sv
design/cdb_arbitrator.sv
design/instr_exec.sv
test/instr_exec_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module instr_exec_tb -f compile.f
	./obj_dir/Vinstr_exec_tb

clean:
	rm -rf obj_dir

/* test/instr_exec_golden.txt */
// kind(0 alu 1 branch 2 flush 3 end) op a b src_a src_b pc imm dest value ex taken target
// src 10 = operand column is ready, else producer tag; flush op = entries still waiting
0 1 00000005 00000007 10 10 0 0 0 0000000c 0 0 0
0 0 00000003 fffffff8 10 10 0 0 1 fffffffb 0 0 0
0 3 f0f0ff00 0ff0f0f0 10 10 0 0 2 00f0f000 0 0 0
0 4 12340000 00005678 10 10 0 0 3 12345678 0 0 0
0 5 aaaaaaaa ffff0000 10 10 0 0 4 5555aaaa 0 0 0
0 6 ffffffff 00000001 10 10 0 0 5 00000001 0 0 0
0 7 00000003 00000004 10 10 0 0 6 00000030 0 0 0
0 8 80000000 0000001f 10 10 0 0 7 00000001 0 0 0
0 0 7fffffff 00000001 10 10 0 0 8 80000000 1 0 0
0 1 0 00000001 8 10 0 0 9 80000001 0 0 0
0 2 0 0 9 6 0 0 a 7fffffd1 0 0 0
1 0 0 0000000c 0 10 00001000 00000010 b 00001008 0 1 00001044
1 3 0 0 a 10 00002000 fffffffe c 00002008 0 1 00001ffc
// Both wait on tag f, which is never produced
1 1 0 0 f 10 00003000 00000001 d 0 0 0 0
0 1 0 0 f 10 0 0 e 0 0 0 0
2 2 0 0 0 0 0 0 0 0 0 0 0
1 4 0 0 10 10 00400000 00000100 0 00400008 0 1 00400404
0 0 80000000 80000000 10 10 0 0 1 00000000 1 0 0
1 2 00000005 0 10 10 00000100 00000003 2 00000108 0 0 00000110
0 5 0 0000ffff 1 10 0 0 3 0000ffff 0 0 0
1 1 0 0000ffff 3 10 00000200 00000020 4 00000208 0 0 00000284
0 8 0 00000004 3 10 0 0 5 00000fff 0 0 0
0 6 0 0 5 1 0 0 6 00000000 0 0 0
0 4 0 80000000 6 10 0 0 7 80000000 0 0 0
1 2 0 0 7 10 00000300 00000001 8 00000308 0 1 00000308
0 2 00000000 00000001 10 10 0 0 9 ffffffff 0 0 0
0 1 0 0 9 9 0 0 a fffffffe 0 0 0
3
